/* dc_control_top.f */
design/dc_control_pkg.sv
design/control_regs.sv
design/reset_hold.sv
design/event_counters.sv
design/led_glow.sv
design/status_led.sv
design/dc_control_top.sv
tb/dc_control_tb.sv

/* tb/dc_control_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dc_control_tb;

    import dc_control_pkg::*;

    localparam int tb_hold_cycles = 20;
    localparam int tb_slow_glow_bit = 8;
    localparam int tb_fast_glow_bit = 5;

    typedef enum logic [2:0] {op_write, op_read, op_pulses, op_hold, op_led} test_op_t;

    typedef struct packed {
        test_op_t op;
        logic [7:0] addr;
        logic [31:0] data;
        axi_resp_t resp;
        logic [31:0] expect_data;
        bit from_model;
        logic [7:0] stall;
    } test_row_t;

    logic control_clock;
    logic reset_dc;
    logic [axi_addr_width-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [axi_data_width-1:0] wdata;
    logic wvalid;
    logic wready;
    axi_resp_t bresp;
    logic bvalid;
    logic bready;
    logic [axi_addr_width-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [axi_data_width-1:0] rdata;
    axi_resp_t rresp;
    logic rvalid;
    logic rready;
    logic pll54_locked;
    logic pll_hdmi_locked;
    logic resync;
    logic force_generate;
    logic hdmi_tx_ready;
    logic dc_nreset;
    logic opt_nreset;
    logic status_led_n;

    test_row_t rows[$];
    logic [15:0] lfsr_state;
    // model index: 0 pll54 lock, 1 hdmi lock, 2 resync
    logic [31:0] model_count [3];
    logic levels [3];
    int dc_low_cycles;
    int opt_low_cycles;
    int led_low_cycles;
    int cycle_count;
    int timeout_limit;
    int error_count;

    dc_control_top #(
        .hold_cycles(tb_hold_cycles),
        .slow_glow_bit(tb_slow_glow_bit),
        .fast_glow_bit(tb_fast_glow_bit)
    ) dc_control_top_i (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .pll54_locked(pll54_locked),
        .pll_hdmi_locked(pll_hdmi_locked),
        .resync(resync),
        .force_generate(force_generate),
        .hdmi_tx_ready(hdmi_tx_ready),
        .dc_nreset(dc_nreset),
        .opt_nreset(opt_nreset),
        .status_led_n(status_led_n)
    );

    always #2 control_clock = ~control_clock;

    always @(posedge control_clock) begin
        cycle_count = cycle_count + 1;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            end_in_failure();
        end
    end

    // low time of the reset lines and the LED
    always @(negedge control_clock) begin
        if (!dc_nreset) dc_low_cycles = dc_low_cycles + 1;
        if (!opt_nreset) opt_low_cycles = opt_low_cycles + 1;
        if (!status_led_n) led_low_cycles = led_low_cycles + 1;
    end

    //////////////////////////////////////////////////
    // error handling and compare tasks

    task automatic end_in_failure;
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t expected);
        if (got !== expected) begin
            error_count = error_count + 1;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            end_in_failure();
        end
    endtask

    task automatic check_data(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            error_count = error_count + 1;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            end_in_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            error_count = error_count + 1;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            end_in_failure();
        end
    endtask

    task automatic check_led(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            error_count = error_count + 1;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            end_in_failure();
        end
    endtask

    //////////////////////////////////////////////////
    // random bits and the event model

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) next = next ^ 16'hB400;
        return next;
    endfunction

    task automatic take_bits(input int count, output int value);
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            value = (value << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // lock losses count on falling edges, resync on rising edges
    task automatic set_input(input int idx, input logic value);
        if (idx < 2 && levels[idx] && !value) model_count[idx] = model_count[idx] + 1;
        if (idx == 2 && !levels[idx] && value) model_count[idx] = model_count[idx] + 1;
        levels[idx] = value;
        case (idx)
            0: pll54_locked = value;
            1: pll_hdmi_locked = value;
            default: resync = value;
        endcase
    endtask

    function automatic logic [31:0] expected_count(input logic [7:0] addr);
        case (addr)
            addr_pll54_loss: return model_count[0];
            addr_hdmi_loss: return model_count[1];
            default: return model_count[2];
        endcase
    endfunction

    //////////////////////////////////////////////////
    // AXI4-Lite manager

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output axi_resp_t resp);
        @(negedge control_clock);
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        @(negedge control_clock);
        while (!(awready && wready)) @(negedge control_clock);
        // hold valid through the handshake edge
        @(negedge control_clock);
        awvalid = 1'b0;
        wvalid = 1'b0;
        while (!bvalid) @(negedge control_clock);
        resp = bresp;
    endtask

    task automatic axi_read(input logic [7:0] addr, input int stall,
                            output logic [31:0] data, output axi_resp_t resp);
        int i;
        @(negedge control_clock);
        araddr = addr;
        arvalid = 1'b1;
        rready = (stall == 0);
        @(negedge control_clock);
        while (!arready) @(negedge control_clock);
        @(negedge control_clock);
        arvalid = 1'b0;
        while (!rvalid) @(negedge control_clock);
        data = rdata;
        resp = rresp;
        if (stall > 0) begin
            // second request has to wait behind the stalled response
            arvalid = 1'b1;
            for (i = 0; i < stall; i++) begin
                @(negedge control_clock);
                check_flag("rvalid", rvalid, 1'b1);
                check_data("rdata", rdata, data);
                check_flag("arready", arready, 1'b0);
            end
            rready = 1'b1;
            @(negedge control_clock);
            while (!arready) @(negedge control_clock);
            @(negedge control_clock);
            arvalid = 1'b0;
            while (!rvalid) @(negedge control_clock);
            check_data("rdata of second read", rdata, data);
        end
    endtask

    //////////////////////////////////////////////////
    // row handlers

    task automatic run_pulses(input int idx);
        int count;
        int width;
        int i;
        take_bits(3, count);
        count = count + 1;
        for (i = 0; i < count; i++) begin
            take_bits(1, width);
            width = width + 4;
            set_input(idx, !levels[idx]);
            repeat (width) @(negedge control_clock);
            set_input(idx, !levels[idx]);
            repeat (width) @(negedge control_clock);
        end
        repeat (8) @(negedge control_clock);
    endtask

    task automatic run_hold(input test_row_t row);
        axi_resp_t resp;
        dc_low_cycles = 0;
        opt_low_cycles = 0;
        led_low_cycles = 0;
        axi_write(addr_control, row.data, resp);
        check_resp("bresp", resp, row.resp);
        while (!dc_nreset || !opt_nreset) @(negedge control_clock);
        repeat (2) @(negedge control_clock);
        check_data("dc_nreset low cycles", dc_low_cycles, row.data[0] ? tb_hold_cycles : 0);
        check_data("opt_nreset low cycles", opt_low_cycles, row.data[1] ? tb_hold_cycles : 0);
        check_data("status_led_n low cycles", led_low_cycles, row.expect_data);
    endtask

    task automatic run_led(input test_row_t row);
        logic start_level;
        bit changed;
        int i;
        set_input(1, row.data[0]);
        hdmi_tx_ready = row.data[1];
        set_input(2, row.data[2]);
        repeat (6) @(negedge control_clock);
        if (row.data[2]) begin
            start_level = status_led_n;
            changed = 1'b0;
            for (i = 0; i < (1 << (tb_fast_glow_bit + 2)); i++) begin
                @(negedge control_clock);
                if (status_led_n !== start_level) changed = 1'b1;
            end
            if (!changed) begin
                $display("status LED did not change while resync was high");
                end_in_failure();
            end
        end else begin
            check_led("status_led_n", status_led_n, row.expect_data[0]);
        end
    endtask

    task automatic run_row(input test_row_t row);
        axi_resp_t resp;
        logic [31:0] data;
        logic [31:0] expected;
        case (row.op)
            op_write: begin
                axi_write(row.addr, row.data, resp);
                check_resp("bresp", resp, row.resp);
            end
            op_read: begin
                axi_read(row.addr, row.stall, data, resp);
                expected = row.from_model ? expected_count(row.addr) : row.expect_data;
                check_resp("rresp", resp, row.resp);
                check_data("rdata", data, expected);
            end
            op_pulses: run_pulses(row.data);
            op_hold: run_hold(row);
            default: run_led(row);
        endcase
    endtask

    function automatic void add_row(input test_op_t op, input logic [7:0] addr,
                                    input logic [31:0] data, input axi_resp_t resp,
                                    input logic [31:0] expect_data, input bit from_model,
                                    input logic [7:0] stall);
        rows.push_back(test_row_t'{op, addr, data, resp, expect_data, from_model, stall});
    endfunction

    //////////////////////////////////////////////////
    // stimulus table

    task automatic build_table;
        // state after reset
        add_row(op_read, addr_status, 32'h0, resp_okay, 32'h3, 1'b0, 8'd0);
        add_row(op_read, addr_pll54_loss, 32'h0, resp_okay, 32'h0, 1'b1, 8'd0);
        add_row(op_read, addr_hdmi_loss, 32'h0, resp_okay, 32'h0, 1'b1, 8'd0);
        add_row(op_read, addr_resync, 32'h0, resp_okay, 32'h0, 1'b1, 8'd0);
        add_row(op_read, addr_control, 32'h0, resp_okay, 32'h0, 1'b0, 8'd0);
        // reset holds with the LED mirroring the line
        add_row(op_hold, addr_control, 32'h9, resp_okay, tb_hold_cycles, 1'b0, 8'd0);
        add_row(op_read, addr_control, 32'h0, resp_okay, 32'h8, 1'b0, 8'd0);
        add_row(op_hold, addr_control, 32'h6, resp_okay, tb_hold_cycles, 1'b0, 8'd0);
        add_row(op_write, addr_control, 32'h0, resp_okay, 32'h0, 1'b0, 8'd0);
        // led data bits: hdmi lock, tx ready, resync
        add_row(op_led, 8'h00, 32'h0, resp_okay, 32'h1, 1'b0, 8'd0);
        add_row(op_led, 8'h00, 32'h3, resp_okay, 32'h0, 1'b0, 8'd0);
        add_row(op_led, 8'h00, 32'h7, resp_okay, 32'h0, 1'b0, 8'd0);
        // status with hdmi lock, tx ready and resync all high
        add_row(op_read, addr_status, 32'h0, resp_okay, 32'h1F, 1'b0, 8'd0);
        add_row(op_led, 8'h00, 32'h3, resp_okay, 32'h0, 1'b0, 8'd0);
        add_row(op_led, 8'h00, 32'h0, resp_okay, 32'h1, 1'b0, 8'd0);
        // random edge counts on each input
        add_row(op_pulses, 8'h00, 32'd0, resp_okay, 32'h0, 1'b0, 8'd0);
        add_row(op_pulses, 8'h00, 32'd1, resp_okay, 32'h0, 1'b0, 8'd0);
        add_row(op_pulses, 8'h00, 32'd2, resp_okay, 32'h0, 1'b0, 8'd0);
        add_row(op_read, addr_pll54_loss, 32'h0, resp_okay, 32'h0, 1'b1, 8'd0);
        add_row(op_read, addr_hdmi_loss, 32'h0, resp_okay, 32'h0, 1'b1, 8'd0);
        add_row(op_read, addr_resync, 32'h0, resp_okay, 32'h0, 1'b1, 8'd0);
        // error responses
        add_row(op_write, addr_status, 32'h1, resp_slverr, 32'h0, 1'b0, 8'd0);
        add_row(op_read, addr_status, 32'h0, resp_okay, 32'h3, 1'b0, 8'd0);
        add_row(op_write, addr_pll54_loss, 32'h5, resp_slverr, 32'h0, 1'b0, 8'd0);
        add_row(op_write, 8'h20, 32'h3, resp_decerr, 32'h0, 1'b0, 8'd0);
        add_row(op_read, 8'h20, 32'h0, resp_decerr, 32'h0, 1'b0, 8'd0);
        // read response held back by rready
        add_row(op_read, addr_resync, 32'h0, resp_okay, 32'h0, 1'b1, 8'd10);
    endtask

    initial begin
        control_clock = 1'b0;
        reset_dc = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        pll54_locked = 1'b1;
        pll_hdmi_locked = 1'b0;
        resync = 1'b0;
        force_generate = 1'b0;
        hdmi_tx_ready = 1'b0;
        levels[0] = 1'b1;
        levels[1] = 1'b0;
        levels[2] = 1'b0;
        model_count[0] = '0;
        model_count[1] = '0;
        model_count[2] = '0;
        lfsr_state = 16'd45218;
        dc_low_cycles = 0;
        opt_low_cycles = 0;
        led_low_cycles = 0;
        cycle_count = 0;
        error_count = 0;
        build_table();
        timeout_limit = rows.size() * 64 + 4 * tb_hold_cycles;
        repeat (16) @(negedge control_clock);
        reset_dc = 1'b0;
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        if (error_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            end_in_failure();
        end
    end

endmodule

`default_nettype wire

/* design/dc_control_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dc_control_top #(
    parameter int hold_cycles = dc_control_pkg::default_hold_cycles,
    parameter int slow_glow_bit = dc_control_pkg::default_slow_glow_bit,
    parameter int fast_glow_bit = dc_control_pkg::default_fast_glow_bit
) (
    input wire control_clock,
    input wire reset_dc,

    input wire [dc_control_pkg::axi_addr_width-1:0] awaddr,
    input wire awvalid,
    output logic awready,
    input wire [dc_control_pkg::axi_data_width-1:0] wdata,
    input wire wvalid,
    output logic wready,
    output dc_control_pkg::axi_resp_t bresp,
    output logic bvalid,
    input wire bready,
    input wire [dc_control_pkg::axi_addr_width-1:0] araddr,
    input wire arvalid,
    output logic arready,
    output logic [dc_control_pkg::axi_data_width-1:0] rdata,
    output dc_control_pkg::axi_resp_t rresp,
    output logic rvalid,
    input wire rready,

    input wire pll54_locked,
    input wire pll_hdmi_locked,
    input wire resync,
    input wire force_generate,
    input wire hdmi_tx_ready,
    output logic dc_nreset,
    output logic opt_nreset,
    output logic status_led_n
);

    import dc_control_pkg::*;

    logic dc_reset_request;
    logic opt_reset_request;
    led_mode_t led_mode;
    logic [count_width-1:0] pll54_loss_count;
    logic [count_width-1:0] hdmi_loss_count;
    logic [count_width-1:0] resync_count;
    logic pll_hdmi_ready;
    logic resync_level;
    logic force_generate_level;
    logic slow_glow;
    logic fast_glow;

    ////////////////////////////////////////////////////
    // register decode
    control_regs control_regs_i (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .dc_nreset(dc_nreset),
        .opt_nreset(opt_nreset),
        .pll_hdmi_ready(pll_hdmi_ready),
        .hdmi_tx_ready(hdmi_tx_ready),
        .resync_level(resync_level),
        .force_generate_level(force_generate_level),
        .pll54_loss_count(pll54_loss_count),
        .hdmi_loss_count(hdmi_loss_count),
        .resync_count(resync_count),
        .dc_reset_request(dc_reset_request),
        .opt_reset_request(opt_reset_request),
        .led_mode(led_mode)
    );

    ////////////////////////////////////////////////////
    // console and optical drive resets
    reset_hold #(.hold_cycles(hold_cycles)) dc_reset_hold_i (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .request(dc_reset_request),
        .nreset(dc_nreset)
    );

    reset_hold #(.hold_cycles(hold_cycles)) opt_reset_hold_i (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .request(opt_reset_request),
        .nreset(opt_nreset)
    );

    event_counters event_counters_i (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .pll54_locked(pll54_locked),
        .pll_hdmi_locked(pll_hdmi_locked),
        .resync(resync),
        .force_generate(force_generate),
        .pll54_loss_count(pll54_loss_count),
        .hdmi_loss_count(hdmi_loss_count),
        .resync_count(resync_count),
        .pll_hdmi_ready(pll_hdmi_ready),
        .resync_level(resync_level),
        .force_generate_level(force_generate_level)
    );

    ////////////////////////////////////////////////////
    // status LED
    led_glow #(.glow_bit(slow_glow_bit)) slow_glow_i (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .glow(slow_glow)
    );

    led_glow #(.glow_bit(fast_glow_bit)) fast_glow_i (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .glow(fast_glow)
    );

    status_led status_led_i (
        .control_clock(control_clock),
        .reset_dc(reset_dc),
        .led_mode(led_mode),
        .pll_hdmi_ready(pll_hdmi_ready),
        .resync_level(resync_level),
        .force_generate_level(force_generate_level),
        .hdmi_tx_ready(hdmi_tx_ready),
        .slow_glow(slow_glow),
        .fast_glow(fast_glow),
        .dc_nreset(dc_nreset),
        .opt_nreset(opt_nreset),
        .status_led_n(status_led_n)
    );

endmodule

`default_nettype wire

/* design/status_led.sv */
`timescale 1ns/1ps
`default_nettype none

module status_led (
    input wire control_clock,
    input wire reset_dc,
    input wire dc_control_pkg::led_mode_t led_mode,
    input wire pll_hdmi_ready,
    input wire resync_level,
    input wire force_generate_level,
    input wire hdmi_tx_ready,
    input wire slow_glow,
    input wire fast_glow,
    input wire dc_nreset,
    input wire opt_nreset,
    output logic status_led_n
);

    import dc_control_pkg::*;

    logic [blink_bit:0] blink_count;
    logic status_next;

    // board state priority, LED is active low
    always_comb begin
        if (!pll_hdmi_ready) begin
            status_next = 1'b1;
        end else if (resync_level) begin
            status_next = ~fast_glow;
        end else if (force_generate_level) begin
            status_next = blink_count[blink_bit] ? ~fast_glow : 1'b1;
        end else if (hdmi_tx_ready) begin
            status_next = 1'b0;
        end else begin
            status_next = ~slow_glow;
        end
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            blink_count <= '0;
            status_led_n <= 1'b1;
        end else begin
            blink_count <= blink_count + 1'b1;
            case (led_mode)
                led_status: status_led_n <= status_next;
                led_dc_reset: status_led_n <= dc_nreset;
                // mode 3 falls in here as well
                default: status_led_n <= opt_nreset;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/led_glow.sv */
`timescale 1ns/1ps
`default_nettype none

module led_glow #(
    parameter int glow_bit = dc_control_pkg::default_slow_glow_bit
) (
    input wire control_clock,
    input wire reset_dc,
    output logic glow
);

    logic [glow_bit:0] glow_count;
    logic [3:0] intensity;
    logic [4:0] glow_acc;

    // top bit picks ramp up or ramp down
    assign intensity = glow_count[glow_bit] ? ~glow_count[glow_bit-1 -: 4]
                                            : glow_count[glow_bit-1 -: 4];

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            glow_count <= '0;
            glow_acc <= '0;
        end else begin
            glow_count <= glow_count + 1'b1;
            // first-order delta-sigma, carry is the pwm output
            glow_acc <= {1'b0, glow_acc[3:0]} + {1'b0, intensity};
        end
    end

    assign glow = glow_acc[4];

endmodule

`default_nettype wire

/* design/event_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module event_counters (
    input wire control_clock,
    input wire reset_dc,
    input wire pll54_locked,
    input wire pll_hdmi_locked,
    input wire resync,
    input wire force_generate,
    output logic [dc_control_pkg::count_width-1:0] pll54_loss_count,
    output logic [dc_control_pkg::count_width-1:0] hdmi_loss_count,
    output logic [dc_control_pkg::count_width-1:0] resync_count,
    output logic pll_hdmi_ready,
    output logic resync_level,
    output logic force_generate_level
);

    import dc_control_pkg::*;

    // bit order: force_generate, resync, pll_hdmi_locked, pll54_locked
    logic [3:0] sync_meta;
    logic [3:0] sync_level;
    logic [2:0] sync_prev;

    logic pll54_loss;
    logic hdmi_loss;
    logic resync_rise;

    ////////////////////////////////////////////////////
    // two-stage synchronizers
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            sync_meta <= '0;
            sync_level <= '0;
            sync_prev <= '0;
        end else begin
            sync_meta <= {force_generate, resync, pll_hdmi_locked, pll54_locked};
            sync_level <= sync_meta;
            sync_prev <= sync_level[2:0];
        end
    end

    // lock losses are falling edges
    assign pll54_loss = sync_prev[0] && !sync_level[0];
    assign hdmi_loss = sync_prev[1] && !sync_level[1];
    assign resync_rise = !sync_prev[2] && sync_level[2];

    assign pll_hdmi_ready = sync_level[1];
    assign resync_level = sync_level[2];
    assign force_generate_level = sync_level[3];

    ////////////////////////////////////////////////////
    // event counters
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            pll54_loss_count <= '0;
            hdmi_loss_count <= '0;
            resync_count <= '0;
        end else begin
            if (pll54_loss) begin
                pll54_loss_count <= pll54_loss_count + 1'b1;
            end
            if (hdmi_loss) begin
                hdmi_loss_count <= hdmi_loss_count + 1'b1;
            end
            if (resync_rise) begin
                resync_count <= resync_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/reset_hold.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_hold #(
    parameter int hold_cycles = dc_control_pkg::default_hold_cycles
) (
    input wire control_clock,
    input wire reset_dc,
    input wire request,
    output logic nreset
);

    localparam int hold_width = $clog2(hold_cycles + 1);

    // cycles left after the current one
    logic [hold_width-1:0] hold_count;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            hold_count <= '0;
            nreset <= 1'b1;
        end else if (request) begin
            // restart even when a hold is running
            hold_count <= hold_width'(hold_cycles - 1);
            nreset <= 1'b0;
        end else if (hold_count != '0) begin
            hold_count <= hold_count - 1'b1;
        end else begin
            nreset <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/control_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module control_regs (
    input wire control_clock,
    input wire reset_dc,

    input wire [dc_control_pkg::axi_addr_width-1:0] awaddr,
    input wire awvalid,
    output logic awready,
    input wire [dc_control_pkg::axi_data_width-1:0] wdata,
    input wire wvalid,
    output logic wready,
    output dc_control_pkg::axi_resp_t bresp,
    output logic bvalid,
    input wire bready,

    input wire [dc_control_pkg::axi_addr_width-1:0] araddr,
    input wire arvalid,
    output logic arready,
    output logic [dc_control_pkg::axi_data_width-1:0] rdata,
    output dc_control_pkg::axi_resp_t rresp,
    output logic rvalid,
    input wire rready,

    input wire dc_nreset,
    input wire opt_nreset,
    input wire pll_hdmi_ready,
    input wire hdmi_tx_ready,
    input wire resync_level,
    input wire force_generate_level,
    input wire [dc_control_pkg::count_width-1:0] pll54_loss_count,
    input wire [dc_control_pkg::count_width-1:0] hdmi_loss_count,
    input wire [dc_control_pkg::count_width-1:0] resync_count,

    output logic dc_reset_request,
    output logic opt_reset_request,
    output dc_control_pkg::led_mode_t led_mode
);

    import dc_control_pkg::*;

    function automatic reg_sel_t decode(input logic [axi_addr_width-1:0] addr);
        reg_sel_t sel;
        case (addr)
            addr_control: sel = sel_control;
            addr_status: sel = sel_status;
            addr_pll54_loss: sel = sel_pll54_loss;
            addr_hdmi_loss: sel = sel_hdmi_loss;
            addr_resync: sel = sel_resync;
            default: sel = sel_none;
        endcase
        return sel;
    endfunction

    reg_sel_t write_sel;
    reg_sel_t read_sel;
    logic write_fire;
    logic read_fire;
    logic [axi_data_width-1:0] read_word;
    axi_resp_t read_resp;

    assign write_sel = decode(awaddr);
    assign read_sel = decode(araddr);
    assign write_fire = awready && awvalid && wready && wvalid;
    assign read_fire = arready && arvalid;

    // self-clearing requests, only from CONTROL
    assign dc_reset_request = write_fire && (write_sel == sel_control) && wdata[0];
    assign opt_reset_request = write_fire && (write_sel == sel_control) && wdata[1];

    ////////////////////////////////////////////////////
    // write channel
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            led_mode <= led_status;
        end else begin
            awready <= 1'b0;
            wready <= 1'b0;
            // accept only when no response is pending
            if (awvalid && wvalid && !bvalid && !awready) begin
                awready <= 1'b1;
                wready <= 1'b1;
            end
            if (write_fire) begin
                bvalid <= 1'b1;
                if (write_sel == sel_control) begin
                    led_mode <= led_mode_t'(wdata[3:2]);
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge control_clock) begin
        if (write_fire) begin
            case (write_sel)
                sel_control: bresp <= resp_okay;
                sel_none: bresp <= resp_decerr;
                default: bresp <= resp_slverr;
            endcase
        end
    end

    ////////////////////////////////////////////////////
    // read channel
    always_comb begin
        read_resp = resp_okay;
        case (read_sel)
            sel_control: read_word = {{(axi_data_width - 4){1'b0}}, led_mode, 2'b00};
            sel_status: read_word = {{(axi_data_width - 6){1'b0}},
                                     force_generate_level, resync_level, hdmi_tx_ready,
                                     pll_hdmi_ready, opt_nreset, dc_nreset};
            sel_pll54_loss: read_word = pll54_loss_count;
            sel_hdmi_loss: read_word = hdmi_loss_count;
            sel_resync: read_word = resync_count;
            default: begin
                read_word = '0;
                read_resp = resp_decerr;
            end
        endcase
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (read_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // read data holds until the next accepted address
    always_ff @(posedge control_clock) begin
        if (read_fire) begin
            rdata <= read_word;
            rresp <= read_resp;
        end
    end

endmodule

`default_nettype wire

/* design/dc_control_pkg.sv */
`default_nettype none

package dc_control_pkg;

    ////////////////////////////////////////////////////
    // bus and counter widths
    localparam int axi_addr_width = 8;
    localparam int axi_data_width = 32;
    localparam int count_width = 32;

    ////////////////////////////////////////////////////
    // timing defaults, taken from the board
    localparam int default_hold_cycles = 32_000_000;
    localparam int default_slow_glow_bit = 26;
    localparam int default_fast_glow_bit = 22;
    // fast glow on/off gating in force-generate state
    localparam int blink_bit = 24;

    ////////////////////////////////////////////////////
    // register map
    localparam logic [axi_addr_width-1:0] addr_control = 8'h00;
    localparam logic [axi_addr_width-1:0] addr_status = 8'h04;
    localparam logic [axi_addr_width-1:0] addr_pll54_loss = 8'h08;
    localparam logic [axi_addr_width-1:0] addr_hdmi_loss = 8'h0C;
    localparam logic [axi_addr_width-1:0] addr_resync = 8'h10;

    // decoded register select
    typedef enum logic [2:0] {
        sel_control,
        sel_status,
        sel_pll54_loss,
        sel_hdmi_loss,
        sel_resync,
        sel_none
    } reg_sel_t;

    // value 3 is treated like led_opt_reset
    typedef enum logic [1:0] {
        led_status = 2'd0,
        led_opt_reset = 2'd1,
        led_dc_reset = 2'd2
    } led_mode_t;

    typedef enum logic [1:0] {
        resp_okay = 2'd0,
        resp_slverr = 2'd2,
        resp_decerr = 2'd3
    } axi_resp_t;

endpackage

`default_nettype wire
